//--- vlog.f
design/decodePkg.sv
design/decodeCtrlIf.sv
design/controlDecoder.sv
design/registerFile.sv
design/operandSelect.sv
design/decodeStage.sv
dv/decodeStageTb.sv

//--- Makefile
# Verilator build for the decode stage

VERILATOR ?= verilator
FILELIST  ?= vlog.f
TOP       ?= decodeStageTb
DUT_TOP   ?= decodeStage
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --assert --timing -Wno-fatal
PASS_TEXT ?= Done: no errors

SOURCES := $(shell grep -v '^+' $(FILELIST))
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR)

# the run passes only if the log holds the pass line.
sim: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- dv/decodeStageTb.sv
// Decode stage testbench
`timescale 1ns/1ps

module decodeStageTb;
        import decodePkg::*;

        logic     Clock;
        logic     rstN;
        logic     regWriteIn;
        word_t    instruction;
        word_t    rData;
        regAddr_t rAddrIn;

        word_t    immData;
        word_t    rsData;
        word_t    rtData;
        regAddr_t rAddrOut;
        logic     regDst;
        logic     branch;
        logic     memRead;
        logic     memToReg;
        logic     aluOp;
        logic     mulOp;
        logic     memWrite;
        logic     aluSrc;
        logic     regWriteOut;
        funct_t   aluFunc;
        shamt_t   shamt;

        int          errorCount;
        int          timeoutCount;
        logic [31:0] lfsrState;

        // register contents as the write port should leave them.
        word_t shadow [32];

        logic [8:0] actCtrl;
        logic [8:0] expCtrl;
        funct_t     expFunc;
        word_t      expImm;
        regAddr_t   expRAddr;
        shamt_t     expShamt;
        word_t      expRs;
        word_t      expRt;

        decodeStage DUT (
                .Clock      (Clock),
                .rstN       (rstN),
                .regWriteIn (regWriteIn),
                .instruction(instruction),
                .rData      (rData),
                .rAddrIn    (rAddrIn),
                .immData    (immData),
                .rsData     (rsData),
                .rtData     (rtData),
                .rAddrOut   (rAddrOut),
                .regDst     (regDst),
                .branch     (branch),
                .memRead    (memRead),
                .memToReg   (memToReg),
                .aluOp      (aluOp),
                .mulOp      (mulOp),
                .memWrite   (memWrite),
                .aluSrc     (aluSrc),
                .regWriteOut(regWriteOut),
                .aluFunc    (aluFunc),
                .shamt      (shamt)
        );

        initial begin
                Clock = 1'b0;
                forever #2 Clock = ~Clock;
        end

        // control bits, msb first: regDst branch memRead memToReg aluOp
        // mulOp memWrite aluSrc regWrite.
        assign actCtrl = {regDst, branch, memRead, memToReg, aluOp,
                          mulOp, memWrite, aluSrc, regWriteOut};

        always @(posedge Clock) begin
                if (!rstN) begin
                        shadow <= '{default: '0};
                end else if (regWriteIn && (rAddrIn != 5'd0)) begin
                        shadow[rAddrIn] <= rData;
                end
        end

        // reference model of the decode rules.
        always_comb begin
                expCtrl = 9'b0;
                expFunc = '0;
                case (instruction[31:26])
                        OP_RTYPE: begin
                                expCtrl = {1'b1, 3'b000, 1'b1, instruction[5:0] == FUNCT_MUL,
                                           2'b00, 1'b1};
                                expFunc = instruction[5:0];
                        end
                        OP_LW: begin
                                expCtrl = 9'b001100011;
                                expFunc = FUNCT_ADD;
                        end
                        OP_SW: begin
                                expCtrl = 9'b000000110;
                                expFunc = FUNCT_ADD;
                        end
                        OP_BEQ: begin
                                expCtrl = 9'b010000000;
                                expFunc = FUNCT_SUB;
                        end
                        OP_ADDI, OP_LUI: begin
                                expCtrl = 9'b000000011;
                                expFunc = FUNCT_ADD;
                        end
                        default: begin
                                expCtrl = 9'b0;
                        end
                endcase
                if (instruction[31:26] == OP_LUI) begin
                        expImm = {instruction[15:0], 16'h0000};
                end else begin
                        expImm = {{16{instruction[15]}}, instruction[15:0]};
                end
                expRAddr = (instruction[31:26] == OP_RTYPE) ? instruction[15:11]
                                                            : instruction[20:16];
                expShamt = instruction[10:6];
                expRs    = shadow[instruction[25:21]];
                expRt    = shadow[instruction[20:16]];
        end

        task automatic reportMismatch(input string name, input word_t got, input word_t exp);
                errorCount++;
                $display("CHECK FAILED %s got %h expected %h at %0t", name, got, exp, $time);
        endtask

        function automatic string ctrlName(input int b);
                case (b)
                        8:       return "regDst";
                        7:       return "branch";
                        6:       return "memRead";
                        5:       return "memToReg";
                        4:       return "aluOp";
                        3:       return "mulOp";
                        2:       return "memWrite";
                        1:       return "aluSrc";
                        default: return "regWriteOut";
                endcase
        endfunction

        for (genvar b = 0; b < 9; b++) begin : ctrlChecks
                ctrlMatch: assert property (@(posedge Clock) disable iff (!rstN)
                        actCtrl[b] == expCtrl[b])
                        else reportMismatch(ctrlName(b), 32'($sampled(actCtrl[b])),
                                            32'($sampled(expCtrl[b])));
        end

        funcMatch: assert property (@(posedge Clock) disable iff (!rstN) aluFunc == expFunc)
                else reportMismatch("aluFunc", 32'($sampled(aluFunc)), 32'($sampled(expFunc)));

        immMatch: assert property (@(posedge Clock) disable iff (!rstN) immData == expImm)
                else reportMismatch("immData", $sampled(immData), $sampled(expImm));

        destMatch: assert property (@(posedge Clock) disable iff (!rstN) rAddrOut == expRAddr)
                else reportMismatch("rAddrOut", 32'($sampled(rAddrOut)), 32'($sampled(expRAddr)));

        shamtMatch: assert property (@(posedge Clock) disable iff (!rstN) shamt == expShamt)
                else reportMismatch("shamt", 32'($sampled(shamt)), 32'($sampled(expShamt)));

        // read ports against the shadow copy, written values show one edge later.
        rsMatch: assert property (@(posedge Clock) disable iff (!rstN) rsData == expRs)
                else reportMismatch("rsData", $sampled(rsData), $sampled(expRs));

        rtMatch: assert property (@(posedge Clock) disable iff (!rstN) rtData == expRt)
                else reportMismatch("rtData", $sampled(rtData), $sampled(expRt));

        // galois form of x^32 + x^22 + x^2 + x + 1.
        function automatic logic [31:0] lfsrNext(input logic [31:0] s);
                return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
        endfunction

        task automatic randomBits(input int n, output word_t value);
                int i;
                value = '0;
                for (i = 0; i < n; i++) begin
                        lfsrState = lfsrNext(lfsrState);
                        value     = {value[30:0], lfsrState[0]};
                end
        endtask

        function automatic word_t rTypeWord(input regAddr_t rs, input regAddr_t rt,
                                            input regAddr_t rd, input funct_t fn);
                return {OP_RTYPE, rs, rt, rd, 5'd0, fn};
        endfunction

        function automatic word_t iTypeWord(input opcode_t op, input regAddr_t rs,
                                            input regAddr_t rt, input imm_t imm);
                return {op, rs, rt, imm};
        endfunction

        task automatic driveCycle(input word_t instr, input logic we, input regAddr_t addr,
                                  input word_t data);
                @(posedge Clock);
                #1;
                instruction = instr;
                regWriteIn  = we;
                rAddrIn     = addr;
                rData       = data;
        endtask

        // puts addr on the rs field and waits for the expected value.
        task automatic waitForRead(input regAddr_t addr, input word_t value, input int limit);
                int   n;
                logic seen;
                seen = 1'b0;
                n    = 0;
                driveCycle(iTypeWord(OP_LW, addr, 5'd0, 16'h0000), 1'b0, 5'd0, 32'h0);
                while (!seen && (n < limit)) begin
                        @(negedge Clock);
                        if (rsData == value) begin
                                seen = 1'b1;
                        end
                        n++;
                end
                if (!seen) begin
                        timeoutCount++;
                        $display("timed out after %0d cycles waiting for register %0d to read %h",
                                 limit, addr, value);
                end
        endtask

        initial begin : watchdog
                int cycles;
                for (cycles = 0; cycles < 5000; cycles++) begin
                        @(posedge Clock);
                end
                $display("simulation did not finish within %0d cycles", cycles);
                $display("Done: errors found");
                $finish;
        end

        initial begin : stimulus
                word_t    r;
                word_t    data;
                word_t    addrBits;
                word_t    weBits;
                word_t    sel;
                word_t    fsel;
                word_t    opBits;
                word_t    instr;
                regAddr_t prevAddr;
                opcode_t  op;
                int       k;

                errorCount   = 0;
                timeoutCount = 0;
                lfsrState    = 32'h171a;
                rstN         = 1'b0;
                regWriteIn   = 1'b0;
                instruction  = '0;
                rData        = '0;
                rAddrIn      = '0;
                repeat (16) @(posedge Clock);
                #1;
                rstN = 1'b1;

                // sweep both read ports over the cleared file.
                for (k = 0; k < 32; k++) begin
                        driveCycle(rTypeWord(k[4:0], 5'(31 - k), 5'd1, FUNCT_ADD),
                                   1'b0, 5'd0, 32'h0);
                end

                // random writes, rs follows the last written register.
                prevAddr = '0;
                for (k = 0; k < 200; k++) begin
                        randomBits(32, r);
                        randomBits(5, addrBits);
                        randomBits(32, data);
                        randomBits(2, weBits);
                        instr = {r[31:26], prevAddr, r[20:0]};
                        driveCycle(instr, weBits[1:0] != 2'b00, addrBits[4:0], data);
                        if (weBits[1:0] != 2'b00) begin
                                prevAddr = addrBits[4:0];
                        end
                end

                randomBits(32, data);
                driveCycle(iTypeWord(OP_ADDI, 5'd0, 5'd9, 16'h0001), 1'b1, 5'd9, data);
                waitForRead(5'd9, data, 4);

                // register zero ignores writes.
                driveCycle(rTypeWord(5'd0, 5'd0, 5'd0, FUNCT_ADD), 1'b1, 5'd0, 32'hffff_ffff);
                waitForRead(5'd0, 32'h0, 4);

                // supported opcodes, random opcodes and forced function codes.
                for (k = 0; k < 120; k++) begin
                        randomBits(3, sel);
                        randomBits(26, r);
                        randomBits(2, fsel);
                        randomBits(6, opBits);
                        case (sel[2:0])
                                3'd0:    op = OP_RTYPE;
                                3'd1:    op = OP_LW;
                                3'd2:    op = OP_SW;
                                3'd3:    op = OP_BEQ;
                                3'd4:    op = OP_ADDI;
                                3'd5:    op = OP_LUI;
                                default: op = opBits[5:0];
                        endcase
                        instr = {op, r[25:0]};
                        if (op == OP_RTYPE) begin
                                case (fsel[1:0])
                                        2'd0:    instr[5:0] = FUNCT_MUL;
                                        2'd1:    instr[5:0] = FUNCT_ADD;
                                        2'd2:    instr[5:0] = FUNCT_SUB;
                                        default: instr[5:0] = r[5:0];
                                endcase
                        end
                        driveCycle(instr, 1'b0, 5'd0, 32'h0);
                end

                // immediate corners on both sides of zero.
                driveCycle(iTypeWord(OP_ADDI, 5'd1, 5'd2, 16'h7fff), 1'b0, 5'd0, 32'h0);
                driveCycle(iTypeWord(OP_ADDI, 5'd3, 5'd4, 16'h8000), 1'b0, 5'd0, 32'h0);
                driveCycle(iTypeWord(OP_LW, 5'd5, 5'd6, 16'hfffc), 1'b0, 5'd0, 32'h0);
                driveCycle(iTypeWord(OP_LUI, 5'd0, 5'd7, 16'h8001), 1'b0, 5'd0, 32'h0);
                driveCycle(iTypeWord(OP_LUI, 5'd0, 5'd8, 16'h1234), 1'b0, 5'd0, 32'h0);
                driveCycle(iTypeWord(OP_BEQ, 5'd9, 5'd10, 16'hffff), 1'b0, 5'd0, 32'h0);

                // let the last inputs reach a sampling edge.
                repeat (2) @(posedge Clock);
                $display("errorCount %0d, timeoutCount %0d", errorCount, timeoutCount);
                if ((errorCount == 0) && (timeoutCount == 0)) begin
                        $display("Done: no errors");
                end else begin
                        $display("Done: errors found");
                end
                $finish;
        end

endmodule

//--- design/decodeStage.sv
// Instruction decode stage
`timescale 1ns/1ps

module decodeStage (
        input  logic                Clock,
        input  logic                rstN,
        input  logic                regWriteIn,
        input  decodePkg::word_t    instruction,
        input  decodePkg::word_t    rData,
        input  decodePkg::regAddr_t rAddrIn,
        output decodePkg::word_t    immData,
        output decodePkg::word_t    rsData,
        output decodePkg::word_t    rtData,
        output decodePkg::regAddr_t rAddrOut,
        output logic                regDst,
        output logic                branch,
        output logic                memRead,
        output logic                memToReg,
        output logic                aluOp,
        output logic                mulOp,
        output logic                memWrite,
        output logic                aluSrc,
        output logic                regWriteOut,
        output decodePkg::funct_t   aluFunc,
        output decodePkg::shamt_t   shamt
);
        import decodePkg::*;

        regAddr_t rsAddr;
        regAddr_t rtAddr;

        // source register fields.
        assign rsAddr = instruction[25:21];
        assign rtAddr = instruction[20:16];

        decodeCtrlIf ctrlIf (
                .Clock(Clock)
        );

        controlDecoder decoder (
                .instruction(instruction),
                .ctrl       (ctrlIf.driver)
        );

        registerFile regFile (
                .Clock    (Clock),
                .rstN     (rstN),
                .writeEn  (regWriteIn),
                .writeAddr(rAddrIn),
                .writeData(rData),
                .rsAddr   (rsAddr),
                .rtAddr   (rtAddr),
                .rsData   (rsData),
                .rtData   (rtData)
        );

        operandSelect operands (
                .instruction(instruction),
                .ctrl       (ctrlIf.user),
                .immData    (immData),
                .rAddrOut   (rAddrOut),
                .shamt      (shamt)
        );

        // control levels out to the execute stage.
        // shiftSel stays inside.
        assign regDst      = ctrlIf.regDst;
        assign branch      = ctrlIf.branch;
        assign memRead     = ctrlIf.memRead;
        assign memToReg    = ctrlIf.memToReg;
        assign aluOp       = ctrlIf.aluOp;
        assign mulOp       = ctrlIf.mulOp;
        assign memWrite    = ctrlIf.memWrite;
        assign aluSrc      = ctrlIf.aluSrc;
        assign regWriteOut = ctrlIf.regWrite;
        assign aluFunc     = ctrlIf.aluFunc;

endmodule

//--- design/operandSelect.sv
// Immediate and destination select
`timescale 1ns/1ps

module operandSelect (
        input  decodePkg::word_t    instruction,
        decodeCtrlIf.user           ctrl,
        output decodePkg::word_t    immData,
        output decodePkg::regAddr_t rAddrOut,
        output decodePkg::shamt_t   shamt
);
        import decodePkg::*;

        imm_t     imm;
        regAddr_t rtField;
        regAddr_t rdField;
        word_t    immSext;
        word_t    immUpper;

        // instruction fields.
        assign imm     = instruction[15:0];
        assign rtField = instruction[20:16];
        assign rdField = instruction[15:11];
        assign shamt   = instruction[10:6];

        // both immediate forms, picked by the lui select.
        assign immSext  = {{16{imm[15]}}, imm};
        assign immUpper = {imm, 16'h0000};
        assign immData  = ctrl.shiftSel ? immUpper : immSext;

        // R-type writes rd, everything else writes rt.
        assign rAddrOut = ctrl.regDst ? rdField : rtField;

        // lui result leaves the low half clear.
        luiLowZero: assert property (@(posedge ctrl.Clock)
                ctrl.shiftSel |-> (immData[15:0] == '0))
                else $error("lui immediate low half %h", immData[15:0]);

endmodule

//--- design/registerFile.sv
// General purpose register file
`timescale 1ns/1ps

module registerFile (
        input  logic                Clock,
        input  logic                rstN,
        input  logic                writeEn,
        input  decodePkg::regAddr_t writeAddr,
        input  decodePkg::word_t    writeData,
        input  decodePkg::regAddr_t rsAddr,
        input  decodePkg::regAddr_t rtAddr,
        output decodePkg::word_t    rsData,
        output decodePkg::word_t    rtData
);
        import decodePkg::*;

        word_t regs [NUM_REGS];

        // write port, reset wins over a write.
        always_ff @(posedge Clock) begin
                if (!rstN) begin
                        for (int i = 0; i < NUM_REGS; i++) begin
                                regs[i] <= '0;
                        end
                end else if (writeEn && (writeAddr != '0)) begin
                        regs[writeAddr] <= writeData;
                end
        end

        // read ports, no bypass of a write in flight.
        // register zero is hardwired.
        assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
        assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

        // zero register never picks up a value once out of reset.
        zeroRegHeld: assert property (@(posedge Clock) disable iff (!rstN)
                regs[0] == '0)
                else $error("register zero holds %h", regs[0]);

endmodule

//--- design/controlDecoder.sv
// Opcode and function decoder
`timescale 1ns/1ps

module controlDecoder (
        input decodePkg::word_t instruction,
        decodeCtrlIf.driver     ctrl
);
        import decodePkg::*;

        opcode_t opcode;
        funct_t  funct;

        assign opcode = instruction[31:26];
        assign funct  = instruction[5:0];

        always_comb begin
                // everything inactive unless the opcode says otherwise.
                ctrl.regDst   = 1'b0;
                ctrl.branch   = 1'b0;
                ctrl.memRead  = 1'b0;
                ctrl.memToReg = 1'b0;
                ctrl.aluOp    = 1'b0;
                ctrl.mulOp    = 1'b0;
                ctrl.memWrite = 1'b0;
                ctrl.aluSrc   = 1'b0;
                ctrl.regWrite = 1'b0;
                ctrl.shiftSel = 1'b0;
                ctrl.aluFunc  = '0;

                case (opcode)
                        OP_RTYPE: begin
                                // alu op comes straight from the function field.
                                ctrl.regDst   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.aluOp    = 1'b1;
                                ctrl.aluFunc  = funct;
                                ctrl.mulOp    = (funct == FUNCT_MUL);
                        end
                        OP_LW: begin
                                ctrl.memRead  = 1'b1;
                                ctrl.memToReg = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.aluFunc  = FUNCT_ADD;
                        end
                        OP_SW: begin
                                ctrl.memWrite = 1'b1;
                                ctrl.aluSrc   = 1'b1;
                                ctrl.aluFunc  = FUNCT_ADD;
                        end
                        OP_BEQ: begin
                                // equality via subtract.
                                ctrl.branch  = 1'b1;
                                ctrl.aluFunc = FUNCT_SUB;
                        end
                        OP_ADDI: begin
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.aluFunc  = FUNCT_ADD;
                        end
                        OP_LUI: begin
                                // upper immediate is added to the zero register.
                                ctrl.aluSrc   = 1'b1;
                                ctrl.regWrite = 1'b1;
                                ctrl.shiftSel = 1'b1;
                                ctrl.aluFunc  = FUNCT_ADD;
                        end
                        default: begin
                                ctrl.aluFunc = '0;
                        end
                endcase
        end

        // a memory access is either a load or a store.
        memExclusive: assert property (@(posedge ctrl.Clock)
                !(ctrl.memRead && ctrl.memWrite))
                else $error("memRead and memWrite both high, opcode %0d", opcode);

        // the multiplier is only used by R-type alu instructions.
        mulNeedsAlu: assert property (@(posedge ctrl.Clock)
                ctrl.mulOp |-> ctrl.aluOp)
                else $error("mulOp without aluOp, opcode %0d", opcode);

endmodule

//--- design/decodeCtrlIf.sv
// Decoded control bundle
`timescale 1ns/1ps

interface decodeCtrlIf (
        input logic Clock
);
        import decodePkg::*;

        // datapath control levels.
        logic   regDst;
        logic   branch;
        logic   memRead;
        logic   memToReg;
        logic   aluOp;
        logic   mulOp;
        logic   memWrite;
        logic   aluSrc;
        logic   regWrite;
        logic   shiftSel;
        funct_t aluFunc;

        // the decoder owns every level.
        modport driver (
                input  Clock,
                output regDst,
                output branch,
                output memRead,
                output memToReg,
                output aluOp,
                output mulOp,
                output memWrite,
                output aluSrc,
                output regWrite,
                output shiftSel,
                output aluFunc
        );

        // operand forming only needs these two.
        modport user (
                input Clock,
                input regDst,
                input shiftSel
        );

endinterface

//--- design/decodePkg.sv
// Decode stage shared definitions
package decodePkg;

        // data and instruction words.
        typedef logic [31:0] word_t;

        // register file index.
        typedef logic [4:0] regAddr_t;

        // primary opcode, bits 31 to 26.
        typedef logic [5:0] opcode_t;

        // alu function code, bits 5 to 0.
        typedef logic [5:0] funct_t;

        // shift amount, bits 10 to 6.
        typedef logic [4:0] shamt_t;

        // raw immediate, bits 15 to 0.
        typedef logic [15:0] imm_t;

        // register file depth.
        localparam int NUM_REGS = 32;

        // supported primary opcodes.
        localparam opcode_t OP_RTYPE = 6'd0;
        localparam opcode_t OP_LW    = 6'd35;
        localparam opcode_t OP_SW    = 6'd43;
        localparam opcode_t OP_BEQ   = 6'd4;
        localparam opcode_t OP_ADDI  = 6'd8;
        localparam opcode_t OP_LUI   = 6'd15;

        // alu function codes.
        // the non-R-type opcodes reuse add and sub for address and compare.
        localparam funct_t FUNCT_ADD = 6'd32;
        localparam funct_t FUNCT_SUB = 6'd34;
        localparam funct_t FUNCT_MUL = 6'd24;

endpackage
